// File: files.f
+incdir+include
logic/apple1_bus_pkg.sv
logic/apple1_ctrl_pkg.sv
logic/sync_ram.sv
logic/bus_arbiter.sv
logic/memory_map.sv
logic/cassette_interface.sv
logic/cpu_timing.sv
logic/apple1_bus_system.sv
verif/apple1_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= apple1_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/apple1_testdata.txt
// columns: opcode address data expected, all hex, one operation per line
// 1 cpu wr, 2 loader wr, 3 cpu rd, 4 download, 5 monitor, 6 key, 7 tape, 8 menu, 9 aci, a cpu ce
a 0000 04 01
1 0000 5a 00
3 0000 00 5a
1 3fff a7 00
3 3fff 00 a7
1 e000 3c 00
3 e000 00 3c
1 efff 81 00
3 efff 00 81
1 4000 77 00 // unmapped, write goes nowhere
3 4000 00 00
3 bfff 00 00
3 f000 00 00
1 0101 33 00
4 0000 01 00 // download on
a 0000 03 00 // cpu ce masked
2 0100 a5 00 // cpu writes 5a to 0101 in the same cycle
2 ff10 c3 00
1 ff10 11 00 // cpu cannot write the monitor
4 0000 00 00
a 0000 03 01
3 0100 00 a5
3 0101 00 33
3 ff10 00 c3
7 0000 01 00 // tape line high
3 c100 00 00
7 0000 00 00
3 c1ff 00 01
6 0000 05 01 // key held 5 cycles
8 0000 06 06 // menu reset 6 cycles
5 0000 01 00 // monitor tape out
9 c000 03 20 // 3 toggles, odd
9 c0ff 01 00 // 4 toggles, even
9 c080 05 20 // 9 toggles, odd

// File: verif/apple1_tb.sv
`timescale 1ns/1ns
`default_nettype none

module apple1_tb;

	// data file opcodes
	typedef enum logic [3:0] {
		op_cpu_write = 4'h1, op_dl_write = 4'h2, op_cpu_read = 4'h3,
		op_download = 4'h4, op_monitor = 4'h5, op_key = 4'h6, op_tape = 4'h7,
		op_menu = 4'h8, op_aci_dwell = 4'h9, op_cpu_ce = 4'ha
	} tb_op_e;

	logic                          sys_clock;
	logic                          rst_n_i;
	apple1_bus_pkg::bus_req_t      cpu_req;
	apple1_bus_pkg::bus_req_t      dl_req;
	logic                          downloading;
	apple1_ctrl_pkg::ctrl_status_t ctrl;
	logic                          tape_rx;
	apple1_bus_pkg::bus_data_t     rdata;
	logic                          cpu_ce;
	logic                          sys_reset;
	logic                          led;
	logic                          audio_l;
	logic                          audio_r;
	logic [15:0]                   words [0:255]; // four words per record

	apple1_bus_system apple1_bus_system_inst (
		.sys_clock     (sys_clock),
		.rst_n_i       (rst_n_i),
		.cpu_req_i     (cpu_req),
		.dl_req_i      (dl_req),
		.downloading_i (downloading),
		.ctrl_i        (ctrl),
		.tape_rx_i     (tape_rx),
		.rdata_o       (rdata),
		.cpu_ce_o      (cpu_ce),
		.sys_reset_o   (sys_reset),
		.led_o         (led),
		.audio_l_o     (audio_l),
		.audio_r_o     (audio_r)
	);

	initial begin
		sys_clock = 1'b0;
		forever #10 sys_clock = ~sys_clock; // 20 ns period
	end

	task automatic abort_run();
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped after a failed check");
	endtask

	task automatic timeout_error(input string what);
		$display("timeout while waiting for %s at t=%0t", what, $time);
		abort_run();
	endtask

	task automatic check_bit(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			$display("MISMATCH t=%0t %s expected=%b actual=%b", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic check_byte(input string name, input apple1_bus_pkg::bus_data_t exp,
		input apple1_bus_pkg::bus_data_t got);
		if (got !== exp) begin
			$display("MISMATCH t=%0t %s expected=%h actual=%h", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic check_region(input apple1_bus_pkg::bus_req_t req,
		input apple1_bus_pkg::bus_data_t exp, input apple1_bus_pkg::bus_data_t got);
		if (got !== exp) begin
			$display("MISMATCH t=%0t rdata_o at addr %h expected=%h actual=%h",
				$time, req.addr, exp, got);
			abort_run();
		end
	endtask

	task automatic cpu_write(input apple1_bus_pkg::bus_addr_t a,
		input apple1_bus_pkg::bus_data_t d);
		@(negedge sys_clock);
		cpu_req = '{addr: a, wdata: d, we: 1'b1};
		@(negedge sys_clock);
		check_bit("led_o", 1'b0, led); // cpu owns the bus
		cpu_req = '0;
	endtask

	// byte shows up one clock after the address
	task automatic cpu_read(input apple1_bus_pkg::bus_addr_t a,
		input apple1_bus_pkg::bus_data_t exp);
		@(negedge sys_clock);
		cpu_req = '{addr: a, wdata: 8'h00, we: 1'b0};
		@(negedge sys_clock);
		check_region(cpu_req, exp, rdata);
		cpu_req = '0;
	endtask

	// cpu writes the inverse next door in the same cycle and loses it
	task automatic loader_write(input apple1_bus_pkg::bus_addr_t a,
		input apple1_bus_pkg::bus_data_t d);
		@(negedge sys_clock);
		dl_req  = '{addr: a, wdata: d, we: 1'b1};
		cpu_req = '{addr: a + 16'd1, wdata: ~d, we: 1'b1};
		@(negedge sys_clock);
		check_bit("led_o", 1'b1, led);
		dl_req  = '0;
		cpu_req = '0;
	endtask

	task automatic wait_ce_pulse();
		int t;
		t = 0;
		do begin
			@(negedge sys_clock);
			t++;
		end while (!cpu_ce && t < 64);
		if (!cpu_ce)
			timeout_error("a cpu_ce_o pulse");
	endtask

	// adds the reset cycles seen until sys_reset_o drops
	task automatic wait_reset_release(inout apple1_bus_pkg::bus_data_t cnt);
		int t;
		t = 0;
		do begin
			@(negedge sys_clock);
			if (sys_reset)
				cnt = cnt + 8'd1;
			t++;
		end while (sys_reset && t < 100);
		if (sys_reset)
			timeout_error("sys_reset_o to fall");
	endtask

	task automatic expect_ce_in_8();
		for (int k = 1; k <= 8; k++) begin
			@(negedge sys_clock);
			check_bit("cpu_ce_o", k == 8, cpu_ce); // one pulse per 8 clocks
		end
	endtask

	task automatic check_ce_run(input int periods, input logic pulses);
		if (pulses) begin
			wait_ce_pulse();
			repeat (periods) expect_ce_in_8();
		end else begin
			repeat (periods * 8) begin
				@(negedge sys_clock);
				check_bit("cpu_ce_o", 1'b0, cpu_ce);
			end
		end
	endtask

	// key gives one edge, menu holds the reset as a level
	task automatic reset_source(input logic is_key, input int hold,
		input apple1_bus_pkg::bus_data_t exp);
		apple1_bus_pkg::bus_data_t cnt;
		cnt = '0;
		@(negedge sys_clock);
		if (is_key)
			ctrl.reset_key = 1'b1;
		else
			ctrl.menu_reset = 1'b1;
		repeat (hold) begin
			@(negedge sys_clock);
			if (sys_reset)
				cnt = cnt + 8'd1;
		end
		ctrl.reset_key  = 1'b0;
		ctrl.menu_reset = 1'b0;
		wait_reset_release(cnt);
		check_byte("sys_reset_o cycles", exp, cnt);
		if (!is_key)
			expect_ce_in_8(); // first enable 8 clocks after the release
	endtask

	// parks the address on the aci page for a number of cpu enables
	task automatic aci_dwell(input apple1_bus_pkg::bus_addr_t a, input int pulses,
		input apple1_bus_pkg::bus_data_t exp);
		apple1_bus_pkg::bus_data_t cnt_l;
		apple1_bus_pkg::bus_data_t cnt_r;
		int seen;
		int t;
		wait_ce_pulse(); // start right after a pulse
		@(negedge sys_clock);
		cpu_req = '{addr: a, wdata: 8'h00, we: 1'b0};
		seen = 0;
		t = 0;
		while (seen < pulses && t < 16 * pulses + 16) begin
			@(negedge sys_clock);
			t++;
			if (cpu_ce)
				seen++;
		end
		if (seen < pulses)
			timeout_error("cpu_ce_o pulses on the aci page");
		@(negedge sys_clock); // last toggle lands on this edge
		cpu_req = '0;
		repeat (4) @(negedge sys_clock); // dac settles
		cnt_l = '0;
		cnt_r = '0;
		repeat (64) begin
			@(negedge sys_clock);
			if (audio_l)
				cnt_l = cnt_l + 8'd1;
			if (audio_r)
				cnt_r = cnt_r + 8'd1;
		end
		check_byte("audio_l_o high cycles", exp, cnt_l);
		check_byte("audio_r_o high cycles", exp, cnt_r);
	endtask

	task automatic run_file();
		tb_op_e op;
		apple1_bus_pkg::bus_addr_t a;
		apple1_bus_pkg::bus_data_t d;
		apple1_bus_pkg::bus_data_t e;
		int i;
		i = 0;
		while (i < 64 && words[4*i] != 16'hffff) begin
			op = tb_op_e'(words[4*i][3:0]);
			a  = words[4*i+1];
			d  = words[4*i+2][7:0];
			e  = words[4*i+3][7:0];
			case (op)
				op_cpu_write: cpu_write(a, d);
				op_dl_write:  loader_write(a, d);
				op_cpu_read:  cpu_read(a, e);
				op_download: begin
					@(negedge sys_clock);
					downloading = d[0];
				end
				op_monitor: begin
					@(negedge sys_clock);
					ctrl.mon_src = apple1_ctrl_pkg::tape_src_e'(d[0]);
				end
				op_tape: begin
					@(negedge sys_clock);
					tape_rx = d[0];
				end
				op_key:       reset_source(1'b1, int'(d), e);
				op_menu:      reset_source(1'b0, int'(d), e);
				op_aci_dwell: aci_dwell(a, int'(d), e);
				op_cpu_ce:    check_ce_run(int'(d), e[0]);
				default: begin
					$display("unknown opcode %h in record %0d of the data file", words[4*i], i);
					abort_run();
				end
			endcase
			i++;
		end
		if (i == 0) begin
			$display("the data file gave no records");
			abort_run();
		end
	endtask

	// low ram on even passes, basic ram on odd ones
	task automatic random_ram();
		logic [31:0] r;
		apple1_bus_pkg::bus_addr_t a;
		for (int n = 0; n < 8; n++) begin
			r = $urandom();
			if (n[0])
				a = {4'he, r[27:16]};
			else
				a = {2'b00, r[29:16]};
			cpu_write(a, r[7:0]);
			cpu_read(a, r[7:0]);
		end
	endtask

	initial begin
		logic [31:0] seed;
		apple1_bus_pkg::bus_data_t cnt;
		rst_n_i     = 1'b0;
		cpu_req     = '0;
		dl_req      = '0;
		downloading = 1'b0;
		ctrl        = '0; // monitor on tape input
		tape_rx     = 1'b1;
		seed        = $urandom(32'h407d_dd69);
		for (int w = 0; w < 256; w++)
			words[w] = 16'hffff; // end marker past the last record
		$readmemh("verif/apple1_testdata.txt", words);
		repeat (2) @(posedge sys_clock);
		@(negedge sys_clock);
		check_bit("sys_reset_o", 1'b1, sys_reset); // held while rst_n_i is low
		rst_n_i = 1'b1;
		cnt = '0;
		wait_reset_release(cnt);
		check_byte("sys_reset_o cycles", 8'd0, cnt); // drops on the first edge after release
		check_bit("cpu_ce_o", 1'b0, cpu_ce);
		check_bit("led_o", 1'b0, led);
		check_bit("audio_l_o", 1'b0, audio_l);
		check_bit("audio_r_o", 1'b0, audio_r);
		expect_ce_in_8();
		run_file();
		random_ram();
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/apple1_bus_system.sv
`timescale 1ns/1ns
`default_nettype none

module apple1_bus_system (
	input  wire                           sys_clock,
	input  wire                           rst_n_i,
	input  apple1_bus_pkg::bus_req_t      cpu_req_i,   // 6502 side
	input  apple1_bus_pkg::bus_req_t      dl_req_i,    // program loader
	input  wire                           downloading_i,
	input  apple1_ctrl_pkg::ctrl_status_t ctrl_i,
	input  wire                           tape_rx_i,
	output apple1_bus_pkg::bus_data_t     rdata_o,
	output logic                          cpu_ce_o,
	output logic                          sys_reset_o,
	output logic                          led_o,
	output logic                          audio_l_o,
	output logic                          audio_r_o
);

	apple1_bus_pkg::bus_req_t   grant_req; // shared memory bus
	apple1_bus_pkg::bus_owner_e owner;
	apple1_bus_pkg::bus_data_t  aci_rdata;
	logic                       cpu_ce;

	cpu_timing cpu_timing_inst (
		.sys_clock     (sys_clock),
		.rst_n_i       (rst_n_i),
		.ctrl_i        (ctrl_i),
		.downloading_i (downloading_i),
		.cpu_ce_o      (cpu_ce),
		.sys_reset_o   (sys_reset_o)
	);

	bus_arbiter bus_arbiter_inst (
		.cpu_req_i     (cpu_req_i),
		.dl_req_i      (dl_req_i),
		.downloading_i (downloading_i),
		.grant_req_o   (grant_req),
		.owner_o       (owner),
		.led_o         (led_o)
	);

	memory_map memory_map_inst (
		.sys_clock   (sys_clock),
		.rst_n_i     (rst_n_i),
		.grant_req_i (grant_req),
		.owner_i     (owner),
		.aci_rdata_i (aci_rdata),
		.rdata_o     (rdata_o)
	);

	// tape toggle watches the granted address, not the cpu's own
	cassette_interface cassette_interface_inst (
		.sys_clock   (sys_clock),
		.rst_n_i     (rst_n_i),
		.addr_i      (grant_req.addr),
		.cpu_ce_i    (cpu_ce),
		.tape_rx_i   (tape_rx_i),
		.mon_src_i   (ctrl_i.mon_src),
		.aci_rdata_o (aci_rdata),
		.audio_l_o   (audio_l_o),
		.audio_r_o   (audio_r_o)
	);

	assign cpu_ce_o = cpu_ce; // external 6502 runs on this enable

endmodule

`default_nettype wire

// File: logic/cpu_timing.sv
`timescale 1ns/1ns
`default_nettype none

`include "apple1_consts.svh"

module cpu_timing (
	input  wire                           sys_clock,
	input  wire                           rst_n_i,
	input  apple1_ctrl_pkg::ctrl_status_t ctrl_i,
	input  wire                           downloading_i,
	output logic                          cpu_ce_o,
	output logic                          sys_reset_o
);

	localparam int CNT_W = $clog2(`CPU_CE_DIV);

	logic             key_q;       // key level, last cycle
	logic             key_edge;
	logic             sys_reset_q;
	logic [CNT_W-1:0] ce_cnt;
	logic             ce_q;

	// only the press matters, a held key would keep the board in reset
	assign key_edge = ctrl_i.reset_key & ~key_q;

	always_ff @(posedge sys_clock) begin
		if (!rst_n_i) begin
			key_q       <= 1'b1; // no edge right out of reset
			sys_reset_q <= 1'b1;
		end else begin
			key_q       <= ctrl_i.reset_key;
			sys_reset_q <= ctrl_i.menu_reset | ctrl_i.reset_button | key_edge;
		end
	end

	// divider restarts with every reset
	always_ff @(posedge sys_clock) begin
		if (!rst_n_i || sys_reset_q) begin
			ce_cnt <= '0;
			ce_q   <= 1'b0;
		end else begin
			if (ce_cnt == CNT_W'(`CPU_CE_DIV - 1))
				ce_cnt <= '0;
			else
				ce_cnt <= ce_cnt + 1'b1;
			// count runs on during a download, only the pulse is held off
			ce_q <= (ce_cnt == CNT_W'(`CPU_CE_DIV - 1)) & ~downloading_i;
		end
	end

	assign cpu_ce_o    = ce_q;
	assign sys_reset_o = sys_reset_q;

endmodule

`default_nettype wire

// File: logic/cassette_interface.sv
`timescale 1ns/1ns
`default_nettype none

`include "apple1_consts.svh"

module cassette_interface (
	input  wire                        sys_clock,
	input  wire                        rst_n_i,
	input  apple1_bus_pkg::bus_addr_t  addr_i,
	input  wire                        cpu_ce_i,
	input  wire                        tape_rx_i,
	input  apple1_ctrl_pkg::tape_src_e mon_src_i,
	output apple1_bus_pkg::bus_data_t  aci_rdata_o,
	output logic                       audio_l_o,
	output logic                       audio_r_o
);

	logic        tape_in_q;  // line comes in inverted
	logic        tape_out_q;
	logic        aci_page;   // address in 0xc000-0xc0ff
	logic        mon_bit;
	logic [16:0] dac_acc;    // bit 16 is the carry out
	logic        audio_q;

	always_ff @(posedge sys_clock) begin
		tape_in_q <= ~tape_rx_i;
	end

	assign aci_page = (addr_i >= `ACI_FIRST) && (addr_i <= `ACI_PAGE_LAST);

	// any cpu access to the low page flips the output
	always_ff @(posedge sys_clock) begin
		if (!rst_n_i)
			tape_out_q <= 1'b0;
		else if (cpu_ce_i && aci_page)
			tape_out_q <= ~tape_out_q;
	end

	// bit 0 carries the tape, upper bits read zero
	assign aci_rdata_o = {{(`APPLE1_DATA_W-1){1'b0}}, tape_in_q};

	assign mon_bit = (mon_src_i == apple1_ctrl_pkg::tape_src_in) ? tape_in_q : tape_out_q;

	// first order sigma-delta, input is the bit at half scale
	always_ff @(posedge sys_clock) begin
		if (!rst_n_i) begin
			dac_acc <= '0;
			audio_q <= 1'b0;
		end else begin
			dac_acc <= {1'b0, dac_acc[15:0]} + {1'b0, mon_bit, 15'b0};
			audio_q <= dac_acc[16]; // one cycle behind the sum
		end
	end

	// same signal on both channels
	assign audio_l_o = audio_q;
	assign audio_r_o = audio_q;

endmodule

`default_nettype wire

// File: logic/memory_map.sv
`timescale 1ns/1ns
`default_nettype none

`include "apple1_consts.svh"

module memory_map (
	input  wire                        sys_clock,
	input  wire                        rst_n_i,
	input  apple1_bus_pkg::bus_req_t   grant_req_i,
	input  apple1_bus_pkg::bus_owner_e owner_i,
	input  apple1_bus_pkg::bus_data_t  aci_rdata_i,
	output apple1_bus_pkg::bus_data_t  rdata_o
);

	localparam int LOW_AW   = $clog2(`LOW_RAM_DEPTH);
	localparam int BASIC_AW = $clog2(`BASIC_DEPTH);
	localparam int MON_AW   = $clog2(`MONITOR_DEPTH);

	apple1_bus_pkg::region_e   region;   // decode of the current address
	apple1_bus_pkg::region_e   region_q; // follows the ram read by one cycle
	apple1_bus_pkg::bus_data_t aci_q;
	apple1_bus_pkg::bus_data_t low_rdata;
	apple1_bus_pkg::bus_data_t basic_rdata;
	apple1_bus_pkg::bus_data_t mon_rdata;
	logic low_we;
	logic basic_we;
	logic mon_we;

	// address decode, first match wins
	always_comb begin
		if (grant_req_i.addr <= `LOW_RAM_LAST)
			region = apple1_bus_pkg::region_low_ram;
		else if (grant_req_i.addr >= `ACI_FIRST && grant_req_i.addr <= `ACI_LAST)
			region = apple1_bus_pkg::region_aci;
		else if (grant_req_i.addr >= `BASIC_FIRST && grant_req_i.addr <= `BASIC_LAST)
			region = apple1_bus_pkg::region_basic;
		else if (grant_req_i.addr >= `MONITOR_FIRST)
			region = apple1_bus_pkg::region_monitor;
		else
			region = apple1_bus_pkg::region_unmapped; // 0x4000-0xbfff among others
	end

	assign low_we   = grant_req_i.we & (region == apple1_bus_pkg::region_low_ram);
	assign basic_we = grant_req_i.we & (region == apple1_bus_pkg::region_basic);
	// monitor is read only to the cpu
	assign mon_we   = grant_req_i.we & (region == apple1_bus_pkg::region_monitor) &
		(owner_i == apple1_bus_pkg::owner_loader);

	sync_ram #(.DEPTH(`LOW_RAM_DEPTH)) low_ram_inst (
		.sys_clock (sys_clock),
		.addr_i    (grant_req_i.addr[LOW_AW-1:0]),
		.wdata_i   (grant_req_i.wdata),
		.we_i      (low_we),
		.rdata_o   (low_rdata)
	);

	sync_ram #(.DEPTH(`BASIC_DEPTH)) basic_ram_inst (
		.sys_clock (sys_clock),
		.addr_i    (grant_req_i.addr[BASIC_AW-1:0]),
		.wdata_i   (grant_req_i.wdata),
		.we_i      (basic_we),
		.rdata_o   (basic_rdata)
	);

	sync_ram #(.DEPTH(`MONITOR_DEPTH)) monitor_ram_inst (
		.sys_clock (sys_clock),
		.addr_i    (grant_req_i.addr[MON_AW-1:0]),
		.wdata_i   (grant_req_i.wdata),
		.we_i      (mon_we),
		.rdata_o   (mon_rdata)
	);

	always_ff @(posedge sys_clock) begin
		if (!rst_n_i)
			region_q <= apple1_bus_pkg::region_unmapped;
		else
			region_q <= region;
		aci_q <= aci_rdata_i; // aci byte lines up with the ram reads
	end

	// pick the byte for last cycle's address
	always_comb begin
		case (region_q)
			apple1_bus_pkg::region_low_ram: rdata_o = low_rdata;
			apple1_bus_pkg::region_aci:     rdata_o = aci_q;
			apple1_bus_pkg::region_basic:   rdata_o = basic_rdata;
			apple1_bus_pkg::region_monitor: rdata_o = mon_rdata;
			default:                        rdata_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: logic/bus_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter (
	input  apple1_bus_pkg::bus_req_t   cpu_req_i,
	input  apple1_bus_pkg::bus_req_t   dl_req_i,
	input  wire                        downloading_i,
	output apple1_bus_pkg::bus_req_t   grant_req_o,
	output apple1_bus_pkg::bus_owner_e owner_o,
	output logic                       led_o
);

	logic dl_owns; // loader has a byte to write

	// loader only takes the bus on its write strobe,
	// between loader bytes the cpu keeps running
	assign dl_owns = downloading_i & dl_req_i.we;

	always_comb begin
		if (dl_owns) begin
			grant_req_o = dl_req_i; // a cpu write this cycle is dropped
			owner_o     = apple1_bus_pkg::owner_loader;
		end else begin
			grant_req_o = cpu_req_i;
			owner_o     = apple1_bus_pkg::owner_cpu;
		end
	end

	// activity light, lit while the loader writes
	assign led_o = (owner_o == apple1_bus_pkg::owner_loader);

endmodule

`default_nettype wire

// File: logic/sync_ram.sv
`timescale 1ns/1ns
`default_nettype none

module sync_ram #(
	parameter int DEPTH = 256,
	localparam int AW = $clog2(DEPTH)
) (
	input  wire                       sys_clock,
	input  wire [AW-1:0]              addr_i,
	input  apple1_bus_pkg::bus_data_t wdata_i,
	input  wire                       we_i,
	output apple1_bus_pkg::bus_data_t rdata_o
);

	apple1_bus_pkg::bus_data_t mem [DEPTH]; // no reset, contents undefined at power up
	apple1_bus_pkg::bus_data_t rdata_q;

	always_ff @(posedge sys_clock) begin
		if (we_i) begin
			mem[addr_i] <= wdata_i;
		end
		rdata_q <= mem[addr_i]; // old byte on a same-cycle write
	end

	assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: logic/apple1_ctrl_pkg.sv
`default_nettype none

package apple1_ctrl_pkg;

	// what the audio monitor listens to
	typedef enum logic {
		tape_src_in  = 1'b0, // latched tape input
		tape_src_out = 1'b1  // aci tape out flop
	} tape_src_e;

	// menu and button levels from the board
	typedef struct packed {
		logic      menu_reset;   // osd menu reset
		logic      reset_button; // board button
		logic      reset_key;    // keyboard reset key level
		tape_src_e mon_src;
	} ctrl_status_t;

endpackage

`default_nettype wire

// File: logic/apple1_bus_pkg.sv
`default_nettype none

`include "apple1_consts.svh"

package apple1_bus_pkg;

	typedef logic [`APPLE1_ADDR_W-1:0] bus_addr_t; // cpu address
	typedef logic [`APPLE1_DATA_W-1:0] bus_data_t; // one byte

	// one request on the shared bus
	typedef struct packed {
		bus_addr_t addr;  // byte address
		bus_data_t wdata; // write byte
		logic      we;    // write strobe
	} bus_req_t;

	// decoded address regions
	typedef enum logic [2:0] {
		region_low_ram  = 3'd0,
		region_aci      = 3'd1,
		region_basic    = 3'd2,
		region_monitor  = 3'd3,
		region_unmapped = 3'd4 // reads zero
	} region_e;

	// who drives the shared bus
	typedef enum logic {
		owner_cpu    = 1'b0,
		owner_loader = 1'b1
	} bus_owner_e;

endpackage

`default_nettype wire

// File: include/apple1_consts.svh
`ifndef APPLE1_CONSTS_SVH
`define APPLE1_CONSTS_SVH

// cpu address and data bus
`define APPLE1_ADDR_W 16
`define APPLE1_DATA_W 8

// low ram, 0x0000 up
`define LOW_RAM_LAST 16'h3fff

// cassette interface window
`define ACI_FIRST 16'hc000
`define ACI_LAST 16'hc1ff
`define ACI_PAGE_LAST 16'hc0ff // low page toggles tape out

// basic ram window
`define BASIC_FIRST 16'he000
`define BASIC_LAST 16'hefff

// monitor area, runs to top of memory
`define MONITOR_FIRST 16'hff00

// memory depths in bytes
`define LOW_RAM_DEPTH 16384
`define BASIC_DEPTH 4096
`define MONITOR_DEPTH 256

// system clocks per cpu clock enable
`define CPU_CE_DIV 8

`endif
